/* cu_ctrl_pkg.sv */
//////////////////////////////
// Control constants and the configuration word layout shared by
// the register block, the routers and the testbench
//////////////////////////////

package cu_ctrl_pkg;

	//////////////////////////////
	// Unit addressing
	//////////////////////////////

	// Unit id field carried in every memory line
	localparam int CU_ID_BITS = 8;

	//////////////////////////////
	// Configuration word
	//////////////////////////////

	localparam int CFG_BITS = 64;

	// Upper half is opaque to this block
	typedef struct packed {
		logic [CFG_BITS/2-1:0] mode;
		logic [CFG_BITS/2-1:0] vertex_cu_count;
	} cu_config_t;

endpackage

/* mem_if_pkg.sv */
//////////////////////////////
// Memory side line formats as seen by the compute units
// Import together with cu_ctrl_pkg for the unit id width
//////////////////////////////

package mem_if_pkg;

	import cu_ctrl_pkg::*;

	//////////////////////////////
	// Field widths
	//////////////////////////////

	localparam int DATA_BITS      = 64;
	localparam int TAG_BITS       = 8;
	localparam int RESP_CODE_BITS = 4;
	localparam int BEAT_BITS      = 2;

	//////////////////////////////
	// Line types
	//////////////////////////////

	// Read or write completion
	typedef struct packed {
		logic                      valid;
		logic [CU_ID_BITS-1:0]     cu_id;
		logic [TAG_BITS-1:0]       tag;
		logic [RESP_CODE_BITS-1:0] resp_code;
	} response_line_t;

	// One beat of read data
	typedef struct packed {
		logic                  valid;
		logic [CU_ID_BITS-1:0] cu_id;
		logic [TAG_BITS-1:0]   tag;
		logic [BEAT_BITS-1:0]  beat;
		logic [DATA_BITS-1:0]  data;
	} data_line_t;

endpackage

/* cu_control_regs.sv */
//////////////////////////////
// Configuration capture, per unit broadcast and enables,
// plus the synchronised reset handed to each compute unit
//////////////////////////////

module cu_control_regs
	import cu_ctrl_pkg::*;
#(
	parameter int NUM_GRAPH_CU  = 4,
	parameter int NUM_VERTEX_CU = 2
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  cu_config_t              cu_configure,
	output logic                    cu_rstn       [NUM_GRAPH_CU],
	output cu_config_t              cu_config_out [NUM_GRAPH_CU],
	output logic [NUM_GRAPH_CU-1:0] enable_cu
);

	cu_config_t cfg_q;
	cu_config_t cfg_unit [NUM_GRAPH_CU];
	logic       rstn_meta [NUM_GRAPH_CU];

	// All zeros means nothing new from the host
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cfg_q <= '0;
		end else if (cu_configure != '0) begin
			cfg_q <= cu_configure;
		end
	end

	//////////////////////////////
	// Per unit copies
	//////////////////////////////

	for (genvar i = 0; i < NUM_GRAPH_CU; i++) begin : g_unit
		localparam logic [CFG_BITS/2-1:0] FIRST_VERTEX = (CFG_BITS/2)'(i * NUM_VERTEX_CU);

		always_ff @(posedge clock or negedge rstn) begin
			if (!rstn) begin
				cfg_unit[i]      <= '0;
				cu_config_out[i] <= '0;
				enable_cu[i]     <= 1'b0;
			end else begin
				cfg_unit[i]      <= cfg_q;
				cu_config_out[i] <= cfg_unit[i];
				// Unit is on when its first vertex unit is wanted
				enable_cu[i]     <= FIRST_VERTEX < cu_config_out[i].vertex_cu_count;
			end
		end

		// Two stage release, assert is immediate
		always_ff @(posedge clock or negedge rstn) begin
			if (!rstn) begin
				rstn_meta[i] <= 1'b0;
				cu_rstn[i]   <= 1'b0;
			end else begin
				rstn_meta[i] <= 1'b1;
				cu_rstn[i]   <= rstn_meta[i];
			end
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Enabled units always form a contiguous run from unit 0
	for (genvar i = 1; i < NUM_GRAPH_CU; i++) begin : g_enable_order
		assert property (@(posedge clock) disable iff (!rstn)
			$rose(enable_cu[i]) |-> &enable_cu[i-1:0])
			else $error("enable_cu[%0d] rose above a disabled unit", i);
	end

endmodule

/* cu_id_demux.sv */
//////////////////////////////
// One to many router for a single line type
// Destination is the top bits of cu_id, one cycle of latency
//////////////////////////////

module cu_id_demux
	import cu_ctrl_pkg::*;
	import mem_if_pkg::*;
#(
	parameter type line_t       = response_line_t,
	parameter int  NUM_GRAPH_CU = 4
) (
	input  logic  clock,
	input  logic  rstn,
	input  line_t line_in,
	output line_t line_out [NUM_GRAPH_CU]
);

	localparam int SEL_BITS = $clog2(NUM_GRAPH_CU);

	logic [SEL_BITS-1:0]     sel;
	logic [NUM_GRAPH_CU-1:0] valid_q;
	line_t                   line_q;

	assign sel = line_in.cu_id[CU_ID_BITS-1 -: SEL_BITS];

	// One hot slot valid, cleared whenever nothing arrives
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			valid_q <= '0;
		end else begin
			valid_q <= '0;
			if (line_in.valid) begin
				valid_q[sel] <= 1'b1;
			end
		end
	end

	// Payload is shared by all slots since only one can be valid
	always_ff @(posedge clock) begin
		if (line_in.valid) begin
			line_q <= line_in;
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_GRAPH_CU; i++) begin
			line_out[i]       = line_q;
			line_out[i].valid = valid_q[i];
		end
	end

	assert property (@(posedge clock) disable iff (!rstn) $onehot0(valid_q))
		else $error("more than one unit selected");

endmodule

/* cu_response_router.sv */
//////////////////////////////
// Routes read responses, write responses and read data to the
// unit named in each line, three cycles from input to output
//////////////////////////////

module cu_response_router
	import mem_if_pkg::*;
#(
	parameter int NUM_GRAPH_CU = 4
) (
	input  logic           clock,
	input  logic           rstn,
	input  response_line_t read_response_in,
	input  response_line_t write_response_in,
	input  data_line_t     read_data_in,
	output response_line_t read_response_cu  [NUM_GRAPH_CU],
	output response_line_t write_response_cu [NUM_GRAPH_CU],
	output data_line_t     read_data_cu      [NUM_GRAPH_CU]
);

	response_line_t read_response_q;
	response_line_t write_response_q;
	data_line_t     read_data_q;

	response_line_t read_response_sel  [NUM_GRAPH_CU];
	response_line_t write_response_sel [NUM_GRAPH_CU];
	data_line_t     read_data_sel      [NUM_GRAPH_CU];

	//////////////////////////////
	// Input stage
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_response_q  <= '0;
			write_response_q <= '0;
			read_data_q      <= '0;
		end else begin
			read_response_q  <= read_response_in;
			write_response_q <= write_response_in;
			read_data_q      <= read_data_in;
		end
	end

	//////////////////////////////
	// Select stage
	//////////////////////////////

	cu_id_demux #(
		.line_t       (response_line_t),
		.NUM_GRAPH_CU (NUM_GRAPH_CU)
	) u_read_response_demux (
		.clock    (clock),
		.rstn     (rstn),
		.line_in  (read_response_q),
		.line_out (read_response_sel)
	);

	cu_id_demux #(
		.line_t       (response_line_t),
		.NUM_GRAPH_CU (NUM_GRAPH_CU)
	) u_write_response_demux (
		.clock    (clock),
		.rstn     (rstn),
		.line_in  (write_response_q),
		.line_out (write_response_sel)
	);

	cu_id_demux #(
		.line_t       (data_line_t),
		.NUM_GRAPH_CU (NUM_GRAPH_CU)
	) u_read_data_demux (
		.clock    (clock),
		.rstn     (rstn),
		.line_in  (read_data_q),
		.line_out (read_data_sel)
	);

	//////////////////////////////
	// Output stage toward the units
	//////////////////////////////

	for (genvar i = 0; i < NUM_GRAPH_CU; i++) begin : g_out
		always_ff @(posedge clock or negedge rstn) begin
			if (!rstn) begin
				read_response_cu[i]  <= '0;
				write_response_cu[i] <= '0;
				read_data_cu[i]      <= '0;
			end else begin
				read_response_cu[i]  <= read_response_sel[i];
				write_response_cu[i] <= write_response_sel[i];
				read_data_cu[i]      <= read_data_sel[i];
			end
		end

		// Back to back strobes on a unit need back to back inputs
		assert property (@(posedge clock) disable iff (!rstn)
			read_response_cu[i].valid |=>
				!read_response_cu[i].valid || $past(read_response_in.valid, 3))
			else $error("read response repeated on unit %0d", i);

		assert property (@(posedge clock) disable iff (!rstn)
			write_response_cu[i].valid |=>
				!write_response_cu[i].valid || $past(write_response_in.valid, 3))
			else $error("write response repeated on unit %0d", i);

		assert property (@(posedge clock) disable iff (!rstn)
			read_data_cu[i].valid |=>
				!read_data_cu[i].valid || $past(read_data_in.valid, 3))
			else $error("read data repeated on unit %0d", i);
	end

endmodule

/* cu_arbiter_control.sv */
//////////////////////////////
// Front end between the host memory interface and the compute units
// Set NUM_GRAPH_CU and NUM_VERTEX_CU here only
//////////////////////////////

module cu_arbiter_control
	import cu_ctrl_pkg::*;
	import mem_if_pkg::*;
#(
	parameter int NUM_GRAPH_CU  = 4,
	parameter int NUM_VERTEX_CU = 2
) (
	input  logic                    clock,
	input  logic                    rstn,

	// Host side
	input  cu_config_t              cu_configure,
	input  response_line_t          read_response_in,
	input  response_line_t          write_response_in,
	input  data_line_t              read_data_in,

	// Unit side
	output logic                    cu_rstn           [NUM_GRAPH_CU],
	output cu_config_t              cu_config_out     [NUM_GRAPH_CU],
	output logic [NUM_GRAPH_CU-1:0] enable_cu,
	output response_line_t          read_response_cu  [NUM_GRAPH_CU],
	output response_line_t          write_response_cu [NUM_GRAPH_CU],
	output data_line_t              read_data_cu      [NUM_GRAPH_CU]
);

	//////////////////////////////
	// Configuration and reset
	//////////////////////////////

	cu_control_regs #(
		.NUM_GRAPH_CU  (NUM_GRAPH_CU),
		.NUM_VERTEX_CU (NUM_VERTEX_CU)
	) u_regs (
		.clock         (clock),
		.rstn          (rstn),
		.cu_configure  (cu_configure),
		.cu_rstn       (cu_rstn),
		.cu_config_out (cu_config_out),
		.enable_cu     (enable_cu)
	);

	//////////////////////////////
	// Memory response routing
	//////////////////////////////

	cu_response_router #(
		.NUM_GRAPH_CU (NUM_GRAPH_CU)
	) u_router (
		.clock             (clock),
		.rstn              (rstn),
		.read_response_in  (read_response_in),
		.write_response_in (write_response_in),
		.read_data_in      (read_data_in),
		.read_response_cu  (read_response_cu),
		.write_response_cu (write_response_cu),
		.read_data_cu      (read_data_cu)
	);

endmodule

/* tb_clock_gen.sv */
//////////////////////////////
// Testbench clock and power-on reset
// 100 ns clock, rstn held low for RESET_CYCLES rising edges
//////////////////////////////

module tb_clock_gen #(
	parameter int RESET_CYCLES = 16,
	parameter int HALF_PERIOD  = 50
) (
	output logic clock,
	output logic rstn
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	// Release lands just after an edge so the DUT sees it on the next one
	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

/* tb_cu_arbiter_control.sv */
//////////////////////////////
// Directed testbench for the compute unit front end
// Covers reset, configuration, enables and routing of all streams
//////////////////////////////

module tb_cu_arbiter_control
	import cu_ctrl_pkg::*;
	import mem_if_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_GRAPH_CU  = 4;
	localparam int NUM_VERTEX_CU = 2;
	localparam int SEL_BITS      = $clog2(NUM_GRAPH_CU);
	localparam int MAX_LINES     = 16;
	localparam int RESET_TIMEOUT = 64;

	logic                    clock;
	logic                    rstn;
	cu_config_t              cu_configure;
	response_line_t          read_response_in;
	response_line_t          write_response_in;
	data_line_t              read_data_in;
	logic                    cu_rstn           [NUM_GRAPH_CU];
	cu_config_t              cu_config_out     [NUM_GRAPH_CU];
	logic [NUM_GRAPH_CU-1:0] enable_cu;
	response_line_t          read_response_cu  [NUM_GRAPH_CU];
	response_line_t          write_response_cu [NUM_GRAPH_CU];
	data_line_t              read_data_cu      [NUM_GRAPH_CU];

	int          check_count;
	int          mismatch_count;
	int          failure_count;
	logic [31:0] lfsr_state;
	// Last configuration word the DUT should hold
	cu_config_t  cfg_model;

	tb_clock_gen #(
		.RESET_CYCLES (16)
	) u_clock_gen (
		.clock (clock),
		.rstn  (rstn)
	);

	cu_arbiter_control #(
		.NUM_GRAPH_CU  (NUM_GRAPH_CU),
		.NUM_VERTEX_CU (NUM_VERTEX_CU)
	) u_cu_arbiter_control (
		.clock             (clock),
		.rstn              (rstn),
		.cu_configure      (cu_configure),
		.read_response_in  (read_response_in),
		.write_response_in (write_response_in),
		.read_data_in      (read_data_in),
		.cu_rstn           (cu_rstn),
		.cu_config_out     (cu_config_out),
		.enable_cu         (enable_cu),
		.read_response_cu  (read_response_cu),
		.write_response_cu (write_response_cu),
		.read_data_cu      (read_data_cu)
	);

	//////////////////////////////
	// Random values and models
	//////////////////////////////

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	function automatic logic [63:0] random_bits(input int width);
		logic [63:0] bits;
		bits = '0;
		for (int b = 0; b < width; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[62:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	// Unit i is on when its first vertex unit index is below the count
	function automatic logic [NUM_GRAPH_CU-1:0] enables_for(input logic [31:0] count);
		logic [NUM_GRAPH_CU-1:0] en;
		for (int i = 0; i < NUM_GRAPH_CU; i++) begin
			en[i] = 32'(i * NUM_VERTEX_CU) < count;
		end
		return en;
	endfunction

	function automatic response_line_t random_response(input logic [SEL_BITS-1:0] dest);
		response_line_t line;
		logic [63:0]    r;
		line.valid = 1'b1;
		r = random_bits(CU_ID_BITS - SEL_BITS);
		line.cu_id = {dest, r[CU_ID_BITS-SEL_BITS-1:0]};
		r = random_bits(TAG_BITS);
		line.tag = r[TAG_BITS-1:0];
		r = random_bits(RESP_CODE_BITS);
		line.resp_code = r[RESP_CODE_BITS-1:0];
		return line;
	endfunction

	function automatic data_line_t random_data(input logic [SEL_BITS-1:0] dest);
		data_line_t  line;
		logic [63:0] r;
		line.valid = 1'b1;
		r = random_bits(CU_ID_BITS - SEL_BITS);
		line.cu_id = {dest, r[CU_ID_BITS-SEL_BITS-1:0]};
		r = random_bits(TAG_BITS);
		line.tag = r[TAG_BITS-1:0];
		r = random_bits(BEAT_BITS);
		line.beat = r[BEAT_BITS-1:0];
		line.data = random_bits(DATA_BITS);
		return line;
	endfunction

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_bit(input string name, input logic actual, input logic expected);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic check_response(input string name, input response_line_t actual,
		input response_line_t expected);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_data(input string name, input data_line_t actual,
		input data_line_t expected);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_config(input string name, input cu_config_t actual,
		input cu_config_t expected);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_enable(input string name, input logic [NUM_GRAPH_CU-1:0] actual,
		input logic [NUM_GRAPH_CU-1:0] expected);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, actual, expected);
		end
	endtask

	// Whole line on the addressed unit, valid low on the rest
	task automatic check_response_units(input string name, input response_line_t lines [NUM_GRAPH_CU],
		input bit expect_valid, input logic [SEL_BITS-1:0] dest, input response_line_t expected);
		for (int u = 0; u < NUM_GRAPH_CU; u++) begin
			if (expect_valid && dest == SEL_BITS'(u)) begin
				check_response($sformatf("%s[%0d]", name, u), lines[u], expected);
			end else begin
				check_bit($sformatf("%s[%0d].valid", name, u), lines[u].valid, 1'b0);
			end
		end
	endtask

	task automatic check_data_units(input string name, input data_line_t lines [NUM_GRAPH_CU],
		input bit expect_valid, input logic [SEL_BITS-1:0] dest, input data_line_t expected);
		for (int u = 0; u < NUM_GRAPH_CU; u++) begin
			if (expect_valid && dest == SEL_BITS'(u)) begin
				check_data($sformatf("%s[%0d]", name, u), lines[u], expected);
			end else begin
				check_bit($sformatf("%s[%0d].valid", name, u), lines[u].valid, 1'b0);
			end
		end
	endtask

	task automatic check_config_units(input cu_config_t expected);
		for (int u = 0; u < NUM_GRAPH_CU; u++) begin
			check_config($sformatf("cu_config_out[%0d]", u), cu_config_out[u], expected);
		end
	endtask

	task automatic check_rstn_units(input logic expected);
		for (int u = 0; u < NUM_GRAPH_CU; u++) begin
			check_bit($sformatf("cu_rstn[%0d]", u), cu_rstn[u], expected);
		end
	endtask

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	// Word is sampled one edge after it is driven
	task automatic apply_config(input logic [31:0] count);
		cu_config_t              word;
		cu_config_t              old_cfg;
		logic [NUM_GRAPH_CU-1:0] old_en;
		logic [63:0]             r;
		r = random_bits(32);
		word.mode = r[31:0];
		word.vertex_cu_count = count;
		old_cfg = cfg_model;
		old_en = enables_for(cfg_model.vertex_cu_count);
		@(posedge clock);
		cu_configure <= word;
		for (int c = 1; c <= 4; c++) begin
			@(posedge clock);
			if (c == 1) begin
				cu_configure <= '0;
			end
			@(negedge clock);
			check_config_units(c >= 3 ? word : old_cfg);
			check_enable("enable_cu", enable_cu, c >= 4 ? enables_for(count) : old_en);
		end
		cfg_model = word;
	endtask

	task automatic route_lines(input int count, input bit all_streams);
		response_line_t      rd_lines [MAX_LINES];
		response_line_t      wr_lines [MAX_LINES];
		data_line_t          dt_lines [MAX_LINES];
		logic [SEL_BITS-1:0] rd_dest  [MAX_LINES];
		logic [SEL_BITS-1:0] wr_dest  [MAX_LINES];
		logic [SEL_BITS-1:0] dt_dest  [MAX_LINES];
		logic [63:0]         r;
		int                  idx;
		int                  k;
		bit                  expect_rd;
		bit                  expect_other;
		for (int n = 0; n < count; n++) begin
			r = random_bits(SEL_BITS);
			rd_dest[n] = r[SEL_BITS-1:0];
			wr_dest[n] = rd_dest[n] + SEL_BITS'(1);
			dt_dest[n] = rd_dest[n] + SEL_BITS'(2);
			rd_lines[n] = random_response(rd_dest[n]);
			wr_lines[n] = random_response(wr_dest[n]);
			dt_lines[n] = random_data(dt_dest[n]);
		end
		for (int c = 0; c < count + 4; c++) begin
			@(posedge clock);
			if (c < count) begin
				read_response_in <= rd_lines[c];
				if (all_streams) begin
					write_response_in <= wr_lines[c];
					read_data_in      <= dt_lines[c];
				end
			end else begin
				read_response_in  <= '0;
				write_response_in <= '0;
				read_data_in      <= '0;
			end
			@(negedge clock);
			// Line driven three edges back is due now
			idx = c - 3;
			expect_rd = idx >= 0 && idx < count;
			expect_other = expect_rd && all_streams;
			k = expect_rd ? idx : 0;
			check_response_units("read_response_cu", read_response_cu, expect_rd,
				rd_dest[k], rd_lines[k]);
			check_response_units("write_response_cu", write_response_cu, expect_other,
				wr_dest[k], wr_lines[k]);
			check_data_units("read_data_cu", read_data_cu, expect_other, dt_dest[k], dt_lines[k]);
		end
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic test_reset_state();
		int waited;
		repeat (4) @(negedge clock);
		if (rstn !== 1'b0) begin
			failure_count++;
			$display("Reset was released before the reset state could be checked");
		end
		check_rstn_units(1'b0);
		check_config_units('0);
		check_enable("enable_cu", enable_cu, '0);
		check_response_units("read_response_cu", read_response_cu, 1'b0, '0, '0);
		check_response_units("write_response_cu", write_response_cu, 1'b0, '0, '0);
		check_data_units("read_data_cu", read_data_cu, 1'b0, '0, '0);
		waited = 0;
		while (rstn !== 1'b1 && waited < RESET_TIMEOUT) begin
			@(negedge clock);
			waited++;
		end
		if (rstn !== 1'b1) begin
			failure_count++;
			$display("Timed out waiting for rstn to be released");
		end else begin
			@(negedge clock);
			check_rstn_units(1'b0);
			@(negedge clock);
			check_rstn_units(1'b1);
		end
	endtask

	task automatic test_configuration();
		apply_config(32'd3);
		apply_config(32'd9);
	endtask

	task automatic test_zero_config();
		for (int c = 0; c < 6; c++) begin
			@(posedge clock);
			cu_configure <= '0;
			@(negedge clock);
			check_config_units(cfg_model);
			check_enable("enable_cu", enable_cu, enables_for(cfg_model.vertex_cu_count));
		end
	endtask

	task automatic test_read_response_routing();
		route_lines(12, 1'b0);
	endtask

	task automatic test_independent_streams();
		route_lines(12, 1'b1);
	endtask

	initial begin
		lfsr_state = 32'h260b_5471;
		cfg_model = '0;
		check_count = 0;
		mismatch_count = 0;
		failure_count = 0;
		cu_configure = '0;
		read_response_in = '0;
		write_response_in = '0;
		read_data_in = '0;
		test_reset_state();
		test_configuration();
		test_zero_config();
		test_read_response_routing();
		test_independent_streams();
		repeat (2) @(negedge clock);
		$display("Checks %0d, mismatches %0d, other failures %0d",
			check_count, mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* sim.f */
cu_ctrl_pkg.sv
mem_if_pkg.sv
cu_control_regs.sv
cu_id_demux.sv
cu_response_router.sv
cu_arbiter_control.sv
tb_clock_gen.sv
tb_cu_arbiter_control.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
	-f sim.f --top-module tb_cu_arbiter_control; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_cu_arbiter_control)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx 'TEST OK'; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1
